/* issue_defines.svh */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

`define ISSUE_INST_WIDTH 32
`define ISSUE_ADDR_WIDTH 32
`define ISSUE_ID_WIDTH   6
`define ISSUE_REG_BITS   5

// instruction field positions.
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11

`define LOAD_USE_CYCLES 2  // cycles a load result stays unavailable.

////////////////////////////////////////////////////////////
// opcodes, top two bits select the group
////////////////////////////////////////////////////////////

`define OP_NOP   6'b000000
`define OP_CMP   6'b001000
`define OP_TEST  6'b001001
`define OP_CMPI  6'b011000
`define OP_TESTI 6'b011001
`define OP_LW    6'b100000
`define OP_SW    6'b100001
`define OP_JR    6'b110001

`endif

/* isa_pkg.sv */
`include "issue_defines.svh"

package isa_pkg;

  // register-register layout.
  typedef struct packed {
    logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
    logic [`RS_MSB-`RS_LSB:0]         rs;
    logic [`RT_MSB-`RT_LSB:0]         rt;
    logic [`RD_MSB-`RD_LSB:0]         rd;
    logic [`RD_LSB-1:0]               unused;
  } r_fmt_t;

  // immediate, memory and jump layout.
  typedef struct packed {
    logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
    logic [`RS_MSB-`RS_LSB:0]         rs;
    logic [`RT_MSB-`RT_LSB:0]         rt;
    logic [`RT_LSB-1:0]               imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  // opcode[5:4].
  typedef enum logic [1:0] {
    GRP_REG_ALU = 2'b00,
    GRP_IMM_ALU = 2'b01,
    GRP_MEM     = 2'b10,
    GRP_JUMP    = 2'b11
  } op_group_t;

  typedef enum logic [1:0] {
    ANY = 2'd0,  // alu or nop.
    MEM = 2'd1,  // load or store.
    BR  = 2'd2   // jump, cmp, test.
  } pipe_class_t;

endpackage

/* issue_pkg.sv */
package issue_pkg;

  typedef struct packed {
    logic uses_src0;
    logic uses_src1;
    logic writes_dest;
  } reg_use_t;

  typedef enum logic [1:0] {
    EMPTY      = 2'd0,
    PAIR       = 2'd1,  // both slots waiting.
    YOUNG_ONLY = 2'd2   // slot 1 waiting.
  } buf_state_t;

endpackage

/* reg_depends.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module reg_depends (
  input  isa_pkg::instr_u            instr,
  output logic [`ISSUE_REG_BITS-1:0] src0,
  output logic [`ISSUE_REG_BITS-1:0] src1,
  output logic [`ISSUE_REG_BITS-1:0] dest,
  output issue_pkg::reg_use_t        reg_use,
  output isa_pkg::pipe_class_t       pclass
);

  logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
  isa_pkg::op_group_t               group;

  assign opcode = instr.r.opcode;  // same bits in both views.
  assign group  = isa_pkg::op_group_t'(opcode[`OPCODE_MSB-`OPCODE_LSB -: 2]);

  always_comb begin
    src0    = '0;
    src1    = '0;
    dest    = '0;
    reg_use = '0;
    pclass  = isa_pkg::ANY;
    case (group)
      isa_pkg::GRP_REG_ALU: begin
        if (opcode != `OP_NOP) begin
          src0              = instr.r.rs;
          src1              = instr.r.rt;
          reg_use.uses_src0 = 1'b1;
          reg_use.uses_src1 = 1'b1;
          if (opcode == `OP_CMP || opcode == `OP_TEST) begin
            pclass = isa_pkg::BR;  // flags only.
          end else begin
            dest                = instr.r.rd;
            reg_use.writes_dest = 1'b1;
          end
        end
      end
      isa_pkg::GRP_IMM_ALU: begin
        src0              = instr.i.rs;
        reg_use.uses_src0 = 1'b1;
        if (opcode == `OP_CMPI || opcode == `OP_TESTI) begin
          pclass = isa_pkg::BR;
        end else begin
          dest                = instr.i.rt;
          reg_use.writes_dest = 1'b1;
        end
      end
      isa_pkg::GRP_MEM: begin
        pclass            = isa_pkg::MEM;
        src0              = instr.i.rs;  // base address.
        reg_use.uses_src0 = 1'b1;
        if (opcode == `OP_LW) begin
          dest                = instr.i.rt;
          reg_use.writes_dest = 1'b1;
        end else if (opcode == `OP_SW) begin
          src1              = instr.i.rt;  // store data.
          reg_use.uses_src1 = 1'b1;
        end
      end
      isa_pkg::GRP_JUMP: begin
        pclass = isa_pkg::BR;
        if (opcode == `OP_JR) begin
          src0              = instr.i.rs;
          reg_use.uses_src0 = 1'b1;
        end
      end
    endcase
  end

endmodule

/* hazard_check.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module hazard_check (
  input  logic [`ISSUE_REG_BITS-1:0] src0_0,
  input  logic [`ISSUE_REG_BITS-1:0] src1_0,
  input  logic [`ISSUE_REG_BITS-1:0] dest_0,
  input  issue_pkg::reg_use_t        use_0,
  input  logic [`ISSUE_REG_BITS-1:0] src0_1,
  input  logic [`ISSUE_REG_BITS-1:0] src1_1,
  input  issue_pkg::reg_use_t        use_1,
  input  logic                       timer_active,
  input  logic [`ISSUE_REG_BITS-1:0] timer_reg,
  output logic                       old_blocked,
  output logic                       young_blocked,
  output logic                       pair_raw
);

  // true when a valid source of the instruction matches r; r0 never counts.
  function automatic logic reads_reg(
    input logic [`ISSUE_REG_BITS-1:0] s0,
    input logic [`ISSUE_REG_BITS-1:0] s1,
    input issue_pkg::reg_use_t        u,
    input logic [`ISSUE_REG_BITS-1:0] r
  );
    return (r != '0) && ((u.uses_src0 && (s0 == r)) || (u.uses_src1 && (s1 == r)));
  endfunction

  ////////////////////////////////////////////////////////////
  // load-use against the pending load
  ////////////////////////////////////////////////////////////

  assign old_blocked   = timer_active && reads_reg(src0_0, src1_0, use_0, timer_reg);
  assign young_blocked = timer_active && reads_reg(src0_1, src1_1, use_1, timer_reg);

  ////////////////////////////////////////////////////////////
  // older dest feeding the younger instruction
  ////////////////////////////////////////////////////////////

  assign pair_raw = use_0.writes_dest && reads_reg(src0_1, src1_1, use_1, dest_0);

endmodule

/* pipe_steer.sv */
`timescale 1ns/1ps

module pipe_steer (
  input  isa_pkg::pipe_class_t pclass_0,
  input  isa_pkg::pipe_class_t pclass_1,
  output logic                 class_conflict,
  output logic                 swap,
  output logic                 single_lane_old,
  output logic                 single_lane_young
);

  // lane 0 is the memory pipe, lane 1 the branch pipe.
  always_comb begin
    class_conflict = 1'b0;
    swap           = 1'b0;
    case (pclass_0)
      isa_pkg::MEM: begin
        class_conflict = (pclass_1 == isa_pkg::MEM);
      end
      isa_pkg::BR: begin
        class_conflict = (pclass_1 == isa_pkg::BR);
        swap           = 1'b1;  // branch older, takes lane 1.
      end
      default: begin
        swap = (pclass_1 == isa_pkg::MEM);  // younger load/store to lane 0.
      end
    endcase
  end

  // lone issue.
  assign single_lane_old   = (pclass_0 == isa_pkg::BR);
  assign single_lane_young = (pclass_1 == isa_pkg::BR);

endmodule

/* load_use_timer.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module load_use_timer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       load_issued,
  input  logic [`ISSUE_REG_BITS-1:0] load_dest,
  output logic                       active,
  output logic [`ISSUE_REG_BITS-1:0] held_reg
);

  localparam int CNT_BITS = $clog2(`LOAD_USE_CYCLES + 1);

  logic [CNT_BITS-1:0] count;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      count <= '0;
    end else if (load_issued) begin
      count <= CNT_BITS'(`LOAD_USE_CYCLES);  // restart on every load.
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_issued) begin
      held_reg <= load_dest;
    end
  end

  assign active = (count != '0);

endmodule

/* issue_ctrl.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         flush,
  input  logic                         in_valid,
  input  logic [`ISSUE_INST_WIDTH-1:0] in_instr0,
  input  logic [`ISSUE_INST_WIDTH-1:0] in_instr1,
  input  logic [`ISSUE_ADDR_WIDTH-1:0] in_pc0,
  input  logic [`ISSUE_ADDR_WIDTH-1:0] in_pc1,
  input  logic [`ISSUE_ID_WIDTH-1:0]   in_id0,
  input  logic [`ISSUE_ID_WIDTH-1:0]   in_id1,
  output logic                         in_ready,
  input  logic                         old_blocked,
  input  logic                         young_blocked,
  input  logic                         pair_raw,
  input  logic                         class_conflict,
  input  logic                         swap,
  input  logic                         single_lane_old,
  input  logic                         single_lane_young,
  output isa_pkg::instr_u              buf_instr0,
  output isa_pkg::instr_u              buf_instr1,
  output logic                         load_issued,
  output logic [`ISSUE_REG_BITS-1:0]   load_dest,
  output logic                         lane0_valid,
  output logic [`ISSUE_INST_WIDTH-1:0] lane0_instr,
  output logic [`ISSUE_ADDR_WIDTH-1:0] lane0_pc,
  output logic [`ISSUE_ID_WIDTH-1:0]   lane0_id,
  output logic                         lane1_valid,
  output logic [`ISSUE_INST_WIDTH-1:0] lane1_instr,
  output logic [`ISSUE_ADDR_WIDTH-1:0] lane1_pc,
  output logic [`ISSUE_ID_WIDTH-1:0]   lane1_id
);

  issue_pkg::buf_state_t        state;
  issue_pkg::buf_state_t        load_state;
  logic [`ISSUE_ADDR_WIDTH-1:0] buf_pc0;
  logic [`ISSUE_ADDR_WIDTH-1:0] buf_pc1;
  logic [`ISSUE_ID_WIDTH-1:0]   buf_id0;
  logic [`ISSUE_ID_WIDTH-1:0]   buf_id1;
  logic                         nop0;
  logic                         nop1;
  logic                         issue_old;
  logic                         issue_young;
  logic                         l0_fire;
  logic                         l1_fire;
  logic                         l0_young;
  logic                         l1_young;

  ////////////////////////////////////////////////////////////
  // issue decision
  ////////////////////////////////////////////////////////////

  always_comb begin
    issue_old   = 1'b0;
    issue_young = 1'b0;
    if (state == issue_pkg::PAIR) begin
      issue_old   = !old_blocked;
      issue_young = !old_blocked && !young_blocked && !pair_raw && !class_conflict;
    end else if (state == issue_pkg::YOUNG_ONLY) begin
      issue_young = !young_blocked;
    end
  end

  // buffer empty after this edge.
  assign in_ready = (state == issue_pkg::EMPTY) ||
                    (state == issue_pkg::PAIR && issue_old && issue_young) ||
                    (state == issue_pkg::YOUNG_ONLY && issue_young);

  ////////////////////////////////////////////////////////////
  // pair buffer
  ////////////////////////////////////////////////////////////

  assign nop0 = (in_instr0[`OPCODE_MSB:`OPCODE_LSB] == `OP_NOP);
  assign nop1 = (in_instr1[`OPCODE_MSB:`OPCODE_LSB] == `OP_NOP);

  always_comb begin
    if (nop0 && nop1) begin
      load_state = issue_pkg::EMPTY;
    end else if (nop0 || nop1) begin
      load_state = issue_pkg::YOUNG_ONLY;  // lone survivor sits in slot 1.
    end else begin
      load_state = issue_pkg::PAIR;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      state <= issue_pkg::EMPTY;
    end else if (in_ready) begin
      state <= in_valid ? load_state : issue_pkg::EMPTY;
    end else if (issue_old) begin
      state <= issue_pkg::YOUNG_ONLY;  // split.
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      buf_instr0 <= in_instr0;
      buf_pc0    <= in_pc0;
      buf_id0    <= in_id0;
      if (nop1) begin
        buf_instr1 <= in_instr0;
        buf_pc1    <= in_pc0;
        buf_id1    <= in_id0;
      end else begin
        buf_instr1 <= in_instr1;
        buf_pc1    <= in_pc1;
        buf_id1    <= in_id1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lanes
  ////////////////////////////////////////////////////////////

  always_comb begin
    l0_fire  = 1'b0;
    l1_fire  = 1'b0;
    l0_young = 1'b0;
    l1_young = 1'b1;
    if (issue_old && issue_young) begin
      l0_fire  = 1'b1;
      l1_fire  = 1'b1;
      l0_young = swap;
      l1_young = !swap;
    end else if (issue_old) begin
      l0_fire  = !single_lane_old;
      l1_fire  = single_lane_old;
      l1_young = 1'b0;
    end else if (issue_young) begin
      l0_fire  = !single_lane_young;
      l1_fire  = single_lane_young;
      l0_young = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      lane0_valid <= 1'b0;
      lane1_valid <= 1'b0;
    end else begin
      lane0_valid <= l0_fire;
      lane1_valid <= l1_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (l0_fire) begin
      lane0_instr <= l0_young ? buf_instr1 : buf_instr0;
      lane0_pc    <= l0_young ? buf_pc1 : buf_pc0;
      lane0_id    <= l0_young ? buf_id1 : buf_id0;
    end
    if (l1_fire) begin
      lane1_instr <= l1_young ? buf_instr1 : buf_instr0;
      lane1_pc    <= l1_young ? buf_pc1 : buf_pc0;
      lane1_id    <= l1_young ? buf_id1 : buf_id0;
    end
  end

  // at most one load per edge, two loads never pair.
  assign load_issued = (issue_old && buf_instr0.i.opcode == `OP_LW) ||
                       (issue_young && buf_instr1.i.opcode == `OP_LW);
  assign load_dest   = (issue_young && buf_instr1.i.opcode == `OP_LW) ?
                       buf_instr1.i.rt : buf_instr0.i.rt;

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         flush,
  input  logic                         in_valid,
  input  logic [`ISSUE_INST_WIDTH-1:0] in_instr0,
  input  logic [`ISSUE_INST_WIDTH-1:0] in_instr1,
  input  logic [`ISSUE_ADDR_WIDTH-1:0] in_pc0,
  input  logic [`ISSUE_ADDR_WIDTH-1:0] in_pc1,
  input  logic [`ISSUE_ID_WIDTH-1:0]   in_id0,
  input  logic [`ISSUE_ID_WIDTH-1:0]   in_id1,
  output logic                         in_ready,
  output logic                         lane0_valid,
  output logic [`ISSUE_INST_WIDTH-1:0] lane0_instr,
  output logic [`ISSUE_ADDR_WIDTH-1:0] lane0_pc,
  output logic [`ISSUE_ID_WIDTH-1:0]   lane0_id,
  output logic                         lane1_valid,
  output logic [`ISSUE_INST_WIDTH-1:0] lane1_instr,
  output logic [`ISSUE_ADDR_WIDTH-1:0] lane1_pc,
  output logic [`ISSUE_ID_WIDTH-1:0]   lane1_id
);

  isa_pkg::instr_u              buf_instr0;
  isa_pkg::instr_u              buf_instr1;
  logic [`ISSUE_REG_BITS-1:0]   src0_0;
  logic [`ISSUE_REG_BITS-1:0]   src1_0;
  logic [`ISSUE_REG_BITS-1:0]   dest_0;
  logic [`ISSUE_REG_BITS-1:0]   src0_1;
  logic [`ISSUE_REG_BITS-1:0]   src1_1;
  issue_pkg::reg_use_t          use_0;
  issue_pkg::reg_use_t          use_1;
  isa_pkg::pipe_class_t         pclass_0;
  isa_pkg::pipe_class_t         pclass_1;
  logic                         old_blocked;
  logic                         young_blocked;
  logic                         pair_raw;
  logic                         class_conflict;
  logic                         swap;
  logic                         single_lane_old;
  logic                         single_lane_young;
  logic                         timer_active;
  logic [`ISSUE_REG_BITS-1:0]   timer_reg;
  logic                         load_issued;
  logic [`ISSUE_REG_BITS-1:0]   load_dest;

  reg_depends u_dep0 (
    .instr   (buf_instr0),
    .src0    (src0_0),
    .src1    (src1_0),
    .dest    (dest_0),
    .reg_use (use_0),
    .pclass  (pclass_0)
  );

  // younger dest only matters once it is the older of a later pair.
  reg_depends u_dep1 (
    .instr   (buf_instr1),
    .src0    (src0_1),
    .src1    (src1_1),
    .dest    (),
    .reg_use (use_1),
    .pclass  (pclass_1)
  );

  hazard_check u_hazard (.*);

  pipe_steer u_steer (.*);

  load_use_timer u_timer (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .load_issued (load_issued),
    .load_dest   (load_dest),
    .active      (timer_active),
    .held_reg    (timer_reg)
  );

  issue_ctrl u_ctrl (.*);

endmodule

/* tb_issue_stage.sv */
`timescale 1ns/1ps
`include "issue_defines.svh"

module tb_issue_stage;

  localparam logic [5:0] OP_ADD  = 6'b000001;
  localparam logic [5:0] OP_ADDI = 6'b010000;
  localparam int         MAX_ROWS = 16;

  logic        clk, reset, flush, in_valid, in_ready;
  logic [31:0] in_instr0, in_instr1, in_pc0, in_pc1;
  logic [5:0]  in_id0, in_id1;
  logic        lane0_valid, lane1_valid;
  logic [31:0] lane0_instr, lane0_pc, lane1_instr, lane1_pc;
  logic [5:0]  lane0_id, lane1_id;

  int          cyc, errors, nid, n_rows, cur, t_start, rnd;
  // issue record and expectation per tag.
  int          cnt[64], iss_cyc[64], iss_lane[64], acc_cyc[64], exp_off[64], exp_lane[64];
  logic [31:0] iss_pc[64], iss_instr[64], exp_instr[64];
  // stimulus table.
  int          t_test[MAX_ROWS], t_off0[MAX_ROWS], t_lane0[MAX_ROWS];
  int          t_off1[MAX_ROWS], t_lane1[MAX_ROWS];
  logic [31:0] t_i0[MAX_ROWS], t_i1[MAX_ROWS];
  logic        t_fl[MAX_ROWS];
  logic [5:0]  rops[7] = '{OP_ADD, OP_ADDI, `OP_CMP, `OP_LW, `OP_SW, `OP_JR, `OP_NOP};

  issue_stage uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  always @(negedge clk) begin
    if (lane0_valid === 1'b1) note_issue(lane0_id, 0, lane0_pc, lane0_instr);
    if (lane1_valid === 1'b1) note_issue(lane1_id, 1, lane1_pc, lane1_instr);
  end

  function automatic logic [31:0] enc(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                      logic [4:0] rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [31:0] pc_of(int id);
    return 32'h1000 + 32'(id * 4);
  endfunction

  // 0 mem lane, 1 branch lane, 2 either, 3 nop.
  function automatic int lane_class(logic [31:0] instr);
    logic [5:0] op;
    op = instr[31:26];
    if (op == `OP_NOP) return 3;
    if (op[5:4] == 2'b10) return 0;
    if (op[5:4] == 2'b11 || op == `OP_CMP || op == `OP_TEST) return 1;
    if (op == `OP_CMPI || op == `OP_TESTI) return 1;
    return 2;
  endfunction

  task automatic note_issue(input logic [5:0] id, input int lane, input logic [31:0] pc,
                            input logic [31:0] instr);
    cnt[id]++;
    iss_cyc[id]   = cyc;
    iss_lane[id]  = lane;
    iss_pc[id]    = pc;
    iss_instr[id] = instr;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input int t, input logic [31:0] i0, input logic [31:0] i1,
                         input logic fl, input int o0, input int l0, input int o1, input int l1);
    t_test[n_rows] = t;
    t_i0[n_rows]   = i0;
    t_i1[n_rows]   = i1;
    t_fl[n_rows]   = fl;
    t_off0[n_rows] = o0;
    t_lane0[n_rows] = l0;
    t_off1[n_rows] = o1;
    t_lane1[n_rows] = l1;
    n_rows++;
  endtask

  task automatic clear_record();
    for (int i = 0; i < 64; i++) begin
      cnt[i]     = 0;
      exp_off[i] = 0;
    end
    nid = 0;
  endtask

  // offers one pair and returns just after the accepting edge.
  task automatic drive_pair(input logic [31:0] i0, input logic [31:0] i1);
    int w;
    w = 0;
    in_instr0 = i0;
    in_instr1 = i1;
    in_pc0    = pc_of(nid);
    in_pc1    = pc_of(nid + 1);
    in_id0    = 6'(nid);
    in_id1    = 6'(nid + 1);
    exp_instr[nid]     = i0;
    exp_instr[nid + 1] = i1;
    in_valid  = 1'b1;
    while (in_ready !== 1'b1 && w < 50) begin
      @(posedge clk);
      #1;
      w++;
    end
    if (in_ready !== 1'b1) begin
      $display("timeout: in_ready never went high for pair at tag %0d", nid);
      errors++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    acc_cyc[nid]     = cyc;
    acc_cyc[nid + 1] = cyc;
    nid += 2;
  endtask

  task automatic drain();
    int  w;
    bit  done;
    w = 0;
    done = 1'b0;
    while (!done && w < 40) begin
      done = 1'b1;
      for (int i = 0; i < nid; i++) if (exp_off[i] > 0 && cnt[i] == 0) done = 1'b0;
      if (!done) begin
        @(posedge clk);
        #1;
        w++;
      end
    end
    if (!done) begin
      $display("timeout: an expected instruction never reached a lane");
      errors++;
    end
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input int t);
    drain();
    for (int i = 0; i < nid; i++) begin
      check_value($sformatf("issue count tag %0d", i), 32'(cnt[i]), 32'(exp_off[i] > 0));
      if (exp_off[i] > 0 && cnt[i] == 1) begin
        check_value($sformatf("issue offset tag %0d", i), 32'(iss_cyc[i] - acc_cyc[i]),
                    32'(exp_off[i]));
        check_value($sformatf("lane tag %0d", i), 32'(iss_lane[i]), 32'(exp_lane[i]));
        check_value($sformatf("lane pc tag %0d", i), iss_pc[i], pc_of(i));
        check_value($sformatf("lane instr tag %0d", i), iss_instr[i], exp_instr[i]);
      end
    end
    $display("test %0d done, %0d errors", t, errors - t_start);
  endtask

  task automatic run_random();
    int  last;
    int  mate;
    int  want;
    logic [31:0] a, b;
    clear_record();
    t_start = errors;
    for (int p = 0; p < 24; p++) begin
      repeat ($urandom % 3) begin
        @(posedge clk);
        #1;
      end
      a = enc(rops[$urandom % 7], 5'($urandom % 6), 5'($urandom % 6), 5'($urandom % 6));
      b = enc(rops[$urandom % 7], 5'($urandom % 6), 5'($urandom % 6), 5'($urandom % 6));
      exp_off[nid]     = (lane_class(a) != 3) ? 1 : 0;
      exp_off[nid + 1] = (lane_class(b) != 3) ? 1 : 0;
      drive_pair(a, b);
    end
    drain();
    last = -1;
    for (int i = 0; i < nid; i++) begin
      check_value($sformatf("issue count tag %0d", i), 32'(cnt[i]), 32'(exp_off[i]));
      if (exp_off[i] > 0 && cnt[i] == 1) begin
        mate = -1;
        for (int j = 0; j < nid; j++) begin
          if (j != i && cnt[j] == 1 && iss_cyc[j] == iss_cyc[i]) mate = j;
        end
        // alu lane follows its partner; two alu ops keep program order.
        if (lane_class(exp_instr[i]) < 2) begin
          want = lane_class(exp_instr[i]);
        end else if (mate < 0) begin
          want = 0;
        end else if (lane_class(exp_instr[mate]) < 2) begin
          want = 1 - lane_class(exp_instr[mate]);
        end else begin
          want = (mate > i) ? 0 : 1;
        end
        check_value($sformatf("lane tag %0d", i), 32'(iss_lane[i]), 32'(want));
        check_value($sformatf("lane pc tag %0d", i), iss_pc[i], pc_of(i));
        check_value($sformatf("lane instr tag %0d", i), iss_instr[i], exp_instr[i]);
        if (last >= 0 && iss_cyc[i] < last) begin
          $display("tag %0d issued before an older instruction", i);
          errors++;
        end
        last = iss_cyc[i];
      end
    end
    $display("test 6 done, %0d errors", errors - t_start);
  endtask

  initial begin
    rnd = $urandom(32'h0c81_cea1);
    cyc = 0;
    errors = 0;
    n_rows = 0;
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    in_instr0 = '0;
    in_instr1 = '0;
    in_pc0 = '0;
    in_pc1 = '0;
    in_id0 = '0;
    in_id1 = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("in_ready", 32'(in_ready), 32'd1);
    check_value("lane0_valid", 32'(lane0_valid), 32'd0);
    check_value("lane1_valid", 32'(lane1_valid), 32'd0);

    ////////////////////////////////////////////////////////////
    // test, pair, flush, then offset and lane of each slot
    ////////////////////////////////////////////////////////////
    add_row(1, enc(OP_ADD, 1, 2, 3), enc(OP_ADD, 4, 5, 6), 0, 1, 0, 1, 1);
    add_row(2, enc(`OP_CMP, 1, 2, 0), enc(`OP_LW, 7, 5, 0), 0, 1, 1, 1, 0);
    add_row(2, enc(`OP_CMP, 3, 4, 0), enc(`OP_NOP, 0, 0, 0), 0, 1, 1, 0, 0);
    add_row(2, enc(`OP_NOP, 0, 0, 0), enc(`OP_JR, 2, 0, 0), 0, 0, 0, 1, 1);
    add_row(2, enc(`OP_NOP, 0, 0, 0), enc(OP_ADD, 1, 2, 8), 0, 0, 0, 1, 0);
    add_row(3, enc(OP_ADD, 1, 2, 3), enc(OP_ADD, 3, 1, 4), 0, 1, 0, 2, 0);
    add_row(3, enc(`OP_LW, 1, 5, 0), enc(`OP_LW, 2, 6, 0), 0, 1, 0, 2, 0);
    add_row(3, enc(`OP_CMP, 1, 2, 0), enc(`OP_CMP, 3, 4, 0), 0, 1, 1, 2, 1);
    add_row(4, enc(`OP_LW, 1, 5, 0), enc(OP_ADD, 1, 2, 9), 0, 1, 0, 1, 1);
    add_row(4, enc(OP_ADD, 1, 2, 7), enc(OP_ADD, 5, 1, 6), 0, 1, 0, 3, 0);
    add_row(4, enc(`OP_LW, 1, 0, 0), enc(`OP_NOP, 0, 0, 0), 0, 1, 0, 0, 0);
    add_row(4, enc(OP_ADD, 0, 1, 6), enc(OP_ADD, 2, 3, 7), 0, 1, 0, 1, 1);
    add_row(5, enc(OP_ADD, 1, 2, 3), enc(OP_ADD, 3, 1, 4), 1, 1, 0, 0, 0);
    add_row(5, enc(`OP_LW, 1, 5, 0), enc(OP_ADD, 5, 1, 6), 1, 1, 0, 0, 0);
    add_row(5, enc(OP_ADD, 1, 2, 3), enc(`OP_CMP, 4, 5, 0), 0, 1, 0, 1, 1);

    cur = -1;
    for (int r = 0; r < n_rows; r++) begin
      if (t_test[r] != cur) begin
        if (cur >= 0) finish_test(cur);
        cur = t_test[r];
        clear_record();
        t_start = errors;
      end
      exp_off[nid]      = t_off0[r];
      exp_lane[nid]     = t_lane0[r];
      exp_off[nid + 1]  = t_off1[r];
      exp_lane[nid + 1] = t_lane1[r];
      drive_pair(t_i0[r], t_i1[r]);
      check_value("in_ready", 32'(in_ready),
                  32'(!(t_fl[r] || t_off0[r] > 1 || t_off1[r] > 1)));
      if (t_fl[r]) begin
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_value("lane0_valid", 32'(lane0_valid), 32'd0);
        check_value("lane1_valid", 32'(lane1_valid), 32'd0);
      end
    end
    finish_test(cur);
    run_random();

    $display("summary: 6 tests, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
isa_pkg.sv
issue_pkg.sv
reg_depends.sv
hazard_check.sv
pipe_steer.sv
load_use_timer.sv
issue_ctrl.sv
issue_stage.sv
tb_issue_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_issue_stage -o sim_issue \
  && ./obj_dir/sim_issue > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "NO ERRORS" sim.log || exit 1
